// ==== mpu_io_hub.f ====
+incdir+hw
hw/mpu_pkg.sv
hw/bus_cycle_fsm.sv
hw/interval_timer.sv
hw/irq_controller.sv
hw/mpu_io_hub.sv
sim/tb_mpu_io_hub.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f mpu_io_hub.f --top-module tb_mpu_io_hub -o tb_sim || exit 1
out=$(./obj_dir/tb_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "sim passed" && exit 0 || exit 1

// ==== sim/tb_mpu_io_hub.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mpu_macros.svh"

module tb_mpu_io_hub import mpu_pkg::*; ();

	localparam logic [1:0] K_BUS    = 2'd0;   // one bus cycle
	localparam logic [1:0] K_SRC    = 2'd1;   // drive the interrupt lines
	localparam logic [1:0] K_WAIT   = 2'd2;   // wait for cause and level
	localparam logic [1:0] M_ACK    = 2'd0;
	localparam logic [1:0] M_ERR    = 2'd1;
	localparam logic [1:0] M_SILENT = 2'd2;   // external target never answers
	localparam int         CYC_LIMIT = 64;
	localparam int         IRQ_LIMIT = 200;

	typedef struct packed {
		logic [1:0]  kind;
		logic        we;
		logic [3:0]  sel;
		logic [1:0]  mode;   // external model behavior for this row
		logic [31:0] adr;
		logic [31:0] dat;    // write data, or line pattern for K_SRC
		logic [31:0] exp;    // read data, or {level, cause} for K_WAIT
		logic        err;
	} row_t;

	logic        clk;
	logic        rst_n;
	bus_req_t    cpu_req;
	bus_rsp_t    cpu_rsp;
	bus_req_t    ext_req;
	bus_rsp_t    ext_rsp;
	logic [28:1] irq_src;
	logic [3:0]  irq;
	logic [7:0]  cause;
	logic        pit_out2;

	row_t        rows[$];
	string       names[$];
	logic [31:0] ext_mem [logic [31:0]];   // keyed by word address
	logic [1:0]  ext_mode;
	logic [3:0]  sel_seen;                 // sel of the last answered cycle
	int          seed;
	int          pit2_pulses;              // pulses seen on the channel 2 port

	mpu_io_hub u_mpu_io_hub (
		.clk_i      (clk),
		.rst_n_i    (rst_n),
		.cpu_req_i  (cpu_req),
		.cpu_rsp_o  (cpu_rsp),
		.ext_req_o  (ext_req),
		.ext_rsp_i  (ext_rsp),
		.irq_src_i  (irq_src),
		.irq_o      (irq),
		.cause_o    (cause),
		.pit_out2_o (pit_out2)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;   // 4 ns period
	end

	// ====================
	// address helpers and memory model contents
	function automatic logic [31:0] pic_reg(input logic [7:0] ofs);
		return {`MPU_PIC_BASE, ofs};
	endfunction

	function automatic logic [31:0] pit_reg(input logic [7:0] ofs);
		return {`MPU_PIT_BASE, ofs};
	endfunction

	// never written words read back a pattern of their own address
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] wa);
		return ext_mem.exists(wa) ? ext_mem[wa] : fill_word(wa);
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_d,
		input logic [31:0] wdat, input logic [3:0] sel);
		logic [31:0] res;
		res = old_d;
		for (int b = 0; b < 4; b++)
			if (sel[b])
				res[b*8 +: 8] = wdat[b*8 +: 8];   // only the selected lanes
		return res;
	endfunction

	// ====================
	// stimulus table
	function automatic void add_row(input string name, input logic [1:0] kind,
		input logic we, input logic [3:0] sel, input logic [1:0] mode,
		input logic [31:0] adr, input logic [31:0] dat, input logic [31:0] exp,
		input logic err);
		rows.push_back('{kind: kind, we: we, sel: sel, mode: mode, adr: adr,
			dat: dat, exp: exp, err: err});
		names.push_back(name);
	endfunction

	function automatic void wr_row(input string name, input logic [31:0] adr,
		input logic [31:0] dat, input logic [3:0] sel);
		add_row(name, K_BUS, 1'b1, sel, M_ACK, adr, dat, '0, 1'b0);
	endfunction

	function automatic void rd_row(input string name, input logic [31:0] adr,
		input logic [31:0] exp);
		add_row(name, K_BUS, 1'b0, 4'hf, M_ACK, adr, '0, exp, 1'b0);
	endfunction

	function automatic void err_row(input string name, input logic [31:0] adr,
		input logic [1:0] mode);
		add_row(name, K_BUS, 1'b0, 4'hf, mode, adr, '0, '0, 1'b1);
	endfunction

	function automatic void src_row(input string name, input logic [31:0] lines);
		add_row(name, K_SRC, 1'b0, 4'h0, M_ACK, '0, lines, '0, 1'b0);
	endfunction

	function automatic void wait_row(input string name, input logic [7:0] cse,
		input logic [3:0] lvl);
		add_row(name, K_WAIT, 1'b0, 4'h0, M_ACK, '0, '0, {20'd0, lvl, cse}, 1'b0);
	endfunction

	function automatic void build_table();
		wr_row("pic level wr", pic_reg(`PIC_LEVEL), 32'h5, 4'hf);
		rd_row("pic level rd", pic_reg(`PIC_LEVEL), 32'h5);
		wr_row("pic enable wr", pic_reg(`PIC_ENABLE), 32'h8010_0200, 4'hf);   // 31, 20, 9
		rd_row("pic enable rd", pic_reg(`PIC_ENABLE), 32'h8010_0200);
		wr_row("pit prescale wr", pit_reg(`PIT_PRESCALE), 32'h3, 4'hf);
		rd_row("pit prescale rd", pit_reg(`PIT_PRESCALE), 32'h3);
		wr_row("pit reload0 wr", pit_reg({4'h0, `PIT_RELOAD}), 32'h6, 4'hf);
		rd_row("pit reload0 rd", pit_reg({4'h0, `PIT_RELOAD}), 32'h6);
		err_row("unmapped io", 32'hff00_0010, M_ACK);
		// external memory, random answer delay
		wr_row("ext wr a", 32'h0000_1000, 32'hdead_beef, 4'hf);
		wr_row("ext wr b", 32'h4000_0024, 32'h1122_3344, 4'hf);
		wr_row("ext wr c", 32'hfe00_0008, 32'h0bad_f00d, 4'hf);
		wr_row("ext wr b lanes", 32'h4000_0024, 32'haabb_ccdd, 4'b0110);
		rd_row("ext rd a", 32'h0000_1000, 32'hdead_beef);
		rd_row("ext rd b", 32'h4000_0024, 32'h11bb_cc44);   // middle lanes replaced
		rd_row("ext rd c", 32'hfe00_0008, 32'h0bad_f00d);
		rd_row("ext rd blank", 32'h0200_0040, fill_word(32'h0200_0040));
		err_row("ext error", 32'h0000_2000, M_ERR);
		err_row("ext timeout", 32'h0000_3000, M_SILENT);
		// timer channel 0 one-shot into source 31
		wr_row("pit ctrl0 start", pit_reg({4'h0, `PIT_CTRL}), 32'h1, 4'hf);
		wait_row("pit irq", 8'd31, 4'h5);
		rd_row("pit ctrl0 done", pit_reg({4'h0, `PIT_CTRL}), 32'h0);
		wr_row("pic clear 31", pic_reg(`PIC_CLEAR), 32'h8000_0000, 4'hf);
		wait_row("pit irq gone", 8'd0, 4'h0);
		// priority and masking, 25 stays masked
		src_row("raise 25 20 9", 32'h0210_0200);
		wait_row("irq 20", 8'd20, 4'h5);
		rd_row("pending 20 9", pic_reg(`PIC_PENDING), 32'h0010_0200);
		wr_row("pic clear 20", pic_reg(`PIC_CLEAR), 32'h0010_0000, 4'hf);
		wait_row("irq 9", 8'd9, 4'h5);
		wr_row("pic clear 9", pic_reg(`PIC_CLEAR), 32'h0000_0200, 4'hf);
		wait_row("irq none", 8'd0, 4'h0);
		rd_row("pending none", pic_reg(`PIC_PENDING), 32'h0);
		src_row("drop lines", 32'h0);
		// timer channel 2 one-shot into source 29 and the top port
		wr_row("pic enable 29", pic_reg(`PIC_ENABLE), 32'h2000_0000, 4'hf);
		wr_row("pit reload2 wr", pit_reg({4'h2, `PIT_RELOAD}), 32'h2, 4'hf);
		wr_row("pit ctrl2 start", pit_reg({4'h2, `PIT_CTRL}), 32'h1, 4'hf);
		wait_row("pit2 irq", 8'd29, 4'h5);
		wr_row("pic clear 29", pic_reg(`PIC_CLEAR), 32'h2000_0000, 4'hf);
		wait_row("pit2 irq gone", 8'd0, 4'h0);
	endfunction

	// ====================
	// checks and the CPU side driver
	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			$display("sim failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic give_up(input string what);
		$display("timeout in %s, the DUT did not respond in time", what);
		$display("sim failed");
		$fatal(1, "stopped on a timeout");
	endtask

	// call right after a rising edge; returns on the ack edge
	task automatic bus_cycle(input row_t r, output logic [31:0] rdat, output logic err,
		output int lat);
		int n;
		cpu_req <= '{cyc: 1'b1, stb: 1'b1, we: r.we, sel: r.sel, adr: r.adr, dat: r.dat};
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > CYC_LIMIT)
				give_up("bus cycle");
		end while (!cpu_rsp.ack);
		rdat = cpu_rsp.dat;
		err  = cpu_rsp.err;
		lat  = n - 1;      // edges after the hub sampled the request
		cpu_req <= '0;     // strobe drops on the ack edge
	endtask

	task automatic wait_irq(input row_t r, input string name);
		int n;
		n = 0;
		while (!(cause == r.exp[7:0] && irq == r.exp[11:8])) begin
			@(posedge clk);
			n++;
			if (n > IRQ_LIMIT)
				give_up({name, " wait"});
		end
	endtask

	// one count per high clk of the channel 2 output
	always @(posedge clk) begin
		if (pit_out2)
			pit2_pulses <= pit2_pulses + 1;
	end

	// ====================
	// external memory model
	initial begin : ext_model
		int          dly;
		logic [31:0] wa;
		ext_rsp  = '0;
		sel_seen = '0;
		seed     = 32'hab58;
		forever begin
			@(posedge clk);
			if (ext_req.cyc && ext_req.stb && ext_mode != M_SILENT) begin
				dly = $random(seed) & 7;   // 0 to 7 idle cycles
				repeat (dly) @(posedge clk);
				wa       = {ext_req.adr[31:2], 2'b00};
				sel_seen = ext_req.sel;
				if (ext_mode == M_ERR) begin
					ext_rsp <= '{ack: 1'b0, err: 1'b1, dat: '0};
				end else if (ext_req.we) begin
					ext_mem[wa] = merge_bytes(read_word(wa), ext_req.dat, ext_req.sel);
					ext_rsp <= '{ack: 1'b1, err: 1'b0, dat: '0};
				end else begin
					ext_rsp <= '{ack: 1'b1, err: 1'b0, dat: read_word(wa)};
				end
				@(posedge clk);
				ext_rsp <= '0;   // one cycle answer
			end
		end
	end

	// ====================
	initial begin : main
		row_t        r;
		logic [31:0] rdat;
		logic        err;
		int          lat;
		rst_n       = 1'b0;
		cpu_req     = '0;
		irq_src     = '0;
		ext_mode    = M_ACK;
		pit2_pulses = 0;
		build_table();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		check("reset outputs", 32'd0, 32'({cpu_rsp.ack, cpu_rsp.err, ext_req.cyc,
			ext_req.stb, pit_out2, irq, cause}));
		foreach (rows[i]) begin
			r = rows[i];
			@(posedge clk);
			case (r.kind)
				K_SRC: irq_src <= r.dat[28:1];
				K_WAIT: wait_irq(r, names[i]);
				default: begin
					ext_mode = r.mode;
					bus_cycle(r, rdat, err, lat);
					check({names[i], " err"}, {31'd0, r.err}, {31'd0, err});
					if (!r.we && !r.err)
						check({names[i], " data"}, r.exp, rdat);
					if (r.adr[31:8] == `MPU_PIC_BASE || r.adr[31:8] == `MPU_PIT_BASE)
						check({names[i], " latency"}, 32'd3, lat);
					else if (r.adr[31:24] == `MPU_IO_PAGE)
						check({names[i], " latency"}, 32'd1, lat);   // hole in io page
					else if (r.mode == M_SILENT)
						check({names[i], " timeout"}, 32'd1, 32'(lat >= `MPU_BUS_TIMEOUT));
					else if (r.mode == M_ACK)
						check({names[i], " sel"}, {28'd0, r.sel}, {28'd0, sel_seen});
				end
			endcase
		end
		// channel 2 ran once as a one-shot
		check("pit out2 pulses", 32'd1, 32'(pit2_pulses));
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/mpu_io_hub.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mpu_macros.svh"

module mpu_io_hub import mpu_pkg::*; (
	input  wire        clk_i,
	input  wire        rst_n_i,
	input  wire        bus_req_t cpu_req_i,
	output bus_rsp_t   cpu_rsp_o,
	output bus_req_t   ext_req_o,
	input  wire        bus_rsp_t ext_rsp_i,
	input  wire [28:1] irq_src_i,
	output logic [3:0] irq_o,
	output logic [7:0] cause_o,
	output logic       pit_out2_o
);

	reg_req_t                pit_req;
	reg_req_t                pic_req;
	reg_rsp_t                pit_rsp;
	reg_rsp_t                pic_rsp;
	logic [`MPU_PIT_CH-1:0]  pit_out;
	logic [`MPU_NUM_SRC-1:0] pic_src;

	// ====================
	// timer channels on the top sources, ch0 highest
	assign pic_src    = {pit_out[0], pit_out[1], pit_out[2], irq_src_i, 1'b0};
	assign pit_out2_o = pit_out[2];

	bus_cycle_fsm u_fsm (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.cpu_req_i (cpu_req_i),
		.cpu_rsp_o (cpu_rsp_o),
		.ext_req_o (ext_req_o),
		.ext_rsp_i (ext_rsp_i),
		.pit_req_o (pit_req),
		.pic_req_o (pic_req),
		.pit_rsp_i (pit_rsp),
		.pic_rsp_i (pic_rsp)
	);

	interval_timer u_pit (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.req_i     (pit_req),
		.rsp_o     (pit_rsp),
		.pit_out_o (pit_out)
	);

	irq_controller u_pic (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.req_i     (pic_req),
		.rsp_o     (pic_rsp),
		.src_i     (pic_src),
		.irq_o     (irq_o),   // level to the core
		.cause_o   (cause_o)
	);

endmodule

`default_nettype wire

// ==== hw/irq_controller.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mpu_macros.svh"

module irq_controller import mpu_pkg::*; (
	input  wire                      clk_i,
	input  wire                      rst_n_i,
	input  wire                      reg_req_t req_i,
	output reg_rsp_t                 rsp_o,
	input  wire [`MPU_NUM_SRC-1:0]   src_i,     // bit 0 unused
	output logic [3:0]               irq_o,
	output logic [7:0]               cause_o
);

	localparam int NS = `MPU_NUM_SRC;

	logic [NS-1:0] src_q;       // previous sample for edge detect
	logic [NS-1:0] enable_q;
	logic [NS-1:0] pending_q;
	logic [NS-1:0] rise;
	logic [NS-1:0] clr_mask;
	logic [3:0]    level_q;
	logic [3:0]    irq_d;
	logic [7:0]    cause_d;
	logic          wr;
	logic [31:0]   rd_dat;
	logic          ack_q;
	logic [31:0]   rdat_q;

	assign wr = req_i.stb & req_i.we;

	// ====================
	// edge detect and pending
	assign rise     = src_i & ~src_q & enable_q & {{(NS-1){1'b1}}, 1'b0};
	assign clr_mask = (wr && req_i.ofs == `PIC_CLEAR) ? NS'(req_i.dat) : '0;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			src_q     <= '0;
			enable_q  <= '0;
			pending_q <= '0;
			level_q   <= '0;
		end else begin
			src_q     <= src_i;
			pending_q <= (pending_q & ~clr_mask) | rise;   // new edge beats clear
			if (wr && req_i.ofs == `PIC_ENABLE)
				enable_q <= NS'(req_i.dat);
			if (wr && req_i.ofs == `PIC_LEVEL)
				level_q <= req_i.dat[3:0];
		end
	end

	// ====================
	// priority encode, highest number wins
	always_comb begin
		cause_d = '0;
		for (int i = 1; i < NS; i++)
			if (pending_q[i])
				cause_d = 8'(i);
		irq_d = (|pending_q) ? level_q : '0;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			irq_o   <= '0;
			cause_o <= '0;
		end else begin
			irq_o   <= irq_d;
			cause_o <= cause_d;
		end
	end

	// ====================
	// register readback
	always_comb begin
		case (req_i.ofs)
			`PIC_ENABLE:  rd_dat = 32'(enable_q);
			`PIC_PENDING: rd_dat = 32'(pending_q);
			`PIC_LEVEL:   rd_dat = {28'd0, level_q};
			default:      rd_dat = '0;   // clear reads as zero
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= req_i.stb;
	end

	always_ff @(posedge clk_i) begin
		if (req_i.stb && !req_i.we)
			rdat_q <= rd_dat;
	end

	assign rsp_o = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

// ==== hw/interval_timer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mpu_macros.svh"

module interval_timer import mpu_pkg::*; (
	input  wire                     clk_i,
	input  wire                     rst_n_i,
	input  wire                     reg_req_t req_i,
	output reg_rsp_t                rsp_o,
	output logic [`MPU_PIT_CH-1:0]  pit_out_o
);

	localparam int CH = `MPU_PIT_CH;

	logic [31:0]   pre_q;          // prescale divisor minus one
	logic [31:0]   pre_cnt_q;
	logic          tick;           // one clk per prescaler period
	logic [31:0]   reload_q [CH];
	logic [31:0]   count_q  [CH];
	logic [CH-1:0] en_q;
	logic [CH-1:0] ar_q;           // auto-reload
	logic [CH-1:0] term;           // terminal count this clk
	logic          wr;
	logic [31:0]   rd_dat;
	logic          ack_q;
	logic [31:0]   rdat_q;

	assign wr   = req_i.stb & req_i.we;
	assign tick = pre_cnt_q == pre_q;

	// ====================
	// shared prescaler
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pre_q     <= '0;
			pre_cnt_q <= '0;
		end else if (wr && req_i.ofs == `PIT_PRESCALE) begin
			pre_q     <= req_i.dat;
			pre_cnt_q <= '0;   // restart the period
		end else begin
			pre_cnt_q <= tick ? '0 : pre_cnt_q + 1'b1;
		end
	end

	// count of 1 (or 0) is the last tick of a period
	always_comb begin
		for (int c = 0; c < CH; c++)
			term[c] = en_q[c] & tick & (count_q[c] <= 32'd1);
	end

	// ====================
	// channels
	always_ff @(posedge clk_i) begin
		for (int c = 0; c < CH; c++)
			if (wr && req_i.ofs == {2'b00, 2'(c), `PIT_RELOAD})
				reload_q[c] <= req_i.dat;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			en_q      <= '0;
			ar_q      <= '0;
			pit_out_o <= '0;
			for (int c = 0; c < CH; c++)
				count_q[c] <= '0;
		end else begin
			for (int c = 0; c < CH; c++) begin
				pit_out_o[c] <= term[c];   // single clk pulse
				if (wr && req_i.ofs == {2'b00, 2'(c), `PIT_CTRL}) begin
					en_q[c] <= req_i.dat[`PIT_CTRL_EN];
					ar_q[c] <= req_i.dat[`PIT_CTRL_AR];
					if (req_i.dat[`PIT_CTRL_EN])
						count_q[c] <= reload_q[c];   // start from reload
				end else if (term[c]) begin
					count_q[c] <= ar_q[c] ? reload_q[c] : '0;
					en_q[c]    <= ar_q[c];   // one-shot stops itself
				end else if (en_q[c] && tick) begin
					count_q[c] <= count_q[c] - 1'b1;
				end
			end
		end
	end

	// ====================
	// register readback
	always_comb begin
		rd_dat = '0;
		if (req_i.ofs == `PIT_PRESCALE)
			rd_dat = pre_q;
		for (int c = 0; c < CH; c++) begin
			if (req_i.ofs == {2'b00, 2'(c), `PIT_RELOAD})
				rd_dat = reload_q[c];
			if (req_i.ofs == {2'b00, 2'(c), `PIT_COUNT})
				rd_dat = count_q[c];   // live value
			if (req_i.ofs == {2'b00, 2'(c), `PIT_CTRL}) begin
				rd_dat[`PIT_CTRL_EN] = en_q[c];
				rd_dat[`PIT_CTRL_AR] = ar_q[c];
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= req_i.stb;
	end

	always_ff @(posedge clk_i) begin
		if (req_i.stb && !req_i.we)
			rdat_q <= rd_dat;
	end

	assign rsp_o = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

// ==== hw/bus_cycle_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mpu_macros.svh"

module bus_cycle_fsm import mpu_pkg::*; (
	input  wire      clk_i,
	input  wire      rst_n_i,
	input  wire      bus_req_t cpu_req_i,
	output bus_rsp_t cpu_rsp_o,
	output bus_req_t ext_req_o,
	input  wire      bus_rsp_t ext_rsp_i,
	output reg_req_t pit_req_o,
	output reg_req_t pic_req_o,
	input  wire      reg_rsp_t pit_rsp_i,
	input  wire      reg_rsp_t pic_rsp_i
);

	localparam int unsigned TMO_W = $clog2(`MPU_BUS_TIMEOUT + 1);

	bus_state_e       state_q;
	target_e          tgt_q;
	target_e          tgt_dec;      // decode of the live address
	logic [TMO_W-1:0] tmo_cnt_q;    // cycles spent waiting on the external bus
	logic             ext_act_q;    // external cyc/stb
	logic             pit_stb_q;
	logic             pic_stb_q;
	logic             rsp_err_q;
	logic [31:0]      rsp_dat_q;
	logic [31:0]      sel_dat;      // read data of the selected target
	logic             cpu_go;
	logic             ext_done;
	logic             tmo_hit;
	logic             int_done;

	// ====================
	// address decode
	always_comb begin
		if (cpu_req_i.adr[31:8] == `MPU_PIC_BASE)
			tgt_dec = TGT_PIC;
		else if (cpu_req_i.adr[31:8] == `MPU_PIT_BASE)
			tgt_dec = TGT_PIT;
		else if (cpu_req_i.adr[31:24] == `MPU_IO_PAGE)
			tgt_dec = TGT_NONE;   // hole in the io page
		else
			tgt_dec = TGT_EXT;
	end

	assign cpu_go   = (state_q == ST_IDLE) && cpu_req_i.cyc && cpu_req_i.stb;
	assign ext_done = ext_rsp_i.ack | ext_rsp_i.err;
	assign tmo_hit  = tmo_cnt_q == TMO_W'(`MPU_BUS_TIMEOUT - 1);
	assign int_done = ((tgt_q == TGT_PIT) && pit_rsp_i.ack) ||
		((tgt_q == TGT_PIC) && pic_rsp_i.ack);

	// response data steering
	always_comb begin
		case (tgt_q)
			TGT_PIT: sel_dat = pit_rsp_i.dat;
			TGT_PIC: sel_dat = pic_rsp_i.dat;
			TGT_EXT: sel_dat = ext_rsp_i.dat;
			default: sel_dat = '0;
		endcase
	end

	// ====================
	// cycle state machine
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q   <= ST_IDLE;
			tgt_q     <= TGT_NONE;
			tmo_cnt_q <= '0;
			ext_act_q <= 1'b0;
			pit_stb_q <= 1'b0;
			pic_stb_q <= 1'b0;
			rsp_err_q <= 1'b0;
		end else begin
			pit_stb_q <= 1'b0;   // strobes are single pulses
			pic_stb_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (cpu_go) begin
						tgt_q     <= tgt_dec;
						tmo_cnt_q <= '0;
						case (tgt_dec)
							TGT_PIT: begin
								pit_stb_q <= 1'b1;
								state_q   <= ST_ACCESS;
							end
							TGT_PIC: begin
								pic_stb_q <= 1'b1;
								state_q   <= ST_ACCESS;
							end
							TGT_EXT: begin
								ext_act_q <= 1'b1;   // held until ack, err or timeout
								state_q   <= ST_ACCESS;
							end
							default: begin
								rsp_err_q <= 1'b1;   // unmapped, error right away
								state_q   <= ST_RESP;
							end
						endcase
					end
				end
				ST_ACCESS: begin
					if (tgt_q == TGT_EXT) begin
						if (ext_done || tmo_hit) begin
							ext_act_q <= 1'b0;
							rsp_err_q <= ext_rsp_i.err | ~ext_rsp_i.ack;   // timeout is err too
							state_q   <= ST_RESP;
						end else begin
							tmo_cnt_q <= tmo_cnt_q + 1'b1;
						end
					end else if (int_done) begin
						rsp_err_q <= 1'b0;
						state_q   <= ST_RESP;
					end
				end
				ST_RESP: begin
					rsp_err_q <= 1'b0;   // err only valid with ack
					state_q   <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// response payload, last ACCESS sample wins
	always_ff @(posedge clk_i) begin
		if (state_q == ST_ACCESS)
			rsp_dat_q <= sel_dat;
		else if (cpu_go)
			rsp_dat_q <= '0;   // unmapped read returns zero
	end

	// ====================
	assign cpu_rsp_o = '{ack: state_q == ST_RESP, err: rsp_err_q, dat: rsp_dat_q};

	// master holds adr/dat stable, only the strobes are ours
	assign ext_req_o = '{cyc: ext_act_q, stb: ext_act_q, we: cpu_req_i.we,
		sel: cpu_req_i.sel, adr: cpu_req_i.adr, dat: cpu_req_i.dat};
	assign pit_req_o = '{stb: pit_stb_q, we: cpu_req_i.we,
		ofs: cpu_req_i.adr[7:0], dat: cpu_req_i.dat};
	assign pic_req_o = '{stb: pic_stb_q, we: cpu_req_i.we,
		ofs: cpu_req_i.adr[7:0], dat: cpu_req_i.dat};

endmodule

`default_nettype wire

// ==== hw/mpu_pkg.sv ====
`default_nettype none

package mpu_pkg;

	// ====================
	// master side bus cycle, wishbone style strobes
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;   // byte lanes, only meaningful on the external bus
		logic [31:0] adr;
		logic [31:0] dat;
	} bus_req_t;

	typedef struct packed {
		logic        ack;
		logic        err;
		logic [31:0] dat;
	} bus_rsp_t;

	// internal register port of the timer and the controller
	typedef struct packed {
		logic        stb;   // single cycle
		logic        we;
		logic [7:0]  ofs;   // byte offset inside the 256 byte window
		logic [31:0] dat;
	} reg_req_t;

	typedef struct packed {
		logic        ack;   // one cycle after stb
		logic [31:0] dat;
	} reg_rsp_t;

	// ====================
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_RESP
	} bus_state_e;

	typedef enum logic [1:0] {
		TGT_NONE,   // unmapped hole in the io page
		TGT_PIT,
		TGT_PIC,
		TGT_EXT
	} target_e;

endpackage

`default_nettype wire

// ==== hw/mpu_macros.svh ====
`ifndef MPU_MACROS_SVH
`define MPU_MACROS_SVH

// ====================
// address map, upper bits of the 32-bit byte address
`define MPU_PIC_BASE    24'hFFDC0F   // interrupt controller window
`define MPU_PIT_BASE    24'hFFDC11   // interval timer window
`define MPU_IO_PAGE     8'hFF        // rest of this page is unmapped

// external bus, cycles in ST_ACCESS before giving up
`define MPU_BUS_TIMEOUT 16

// source 0 reads as "no interrupt"
`define MPU_NUM_SRC     32
`define MPU_PIT_CH      3

// ====================
// timer registers, per channel at ch*16 plus these
`define PIT_RELOAD      4'h0
`define PIT_COUNT       4'h4
`define PIT_CTRL        4'h8
`define PIT_PRESCALE    8'h30        // shared prescaler
`define PIT_CTRL_EN     0            // ctrl bit, channel running
`define PIT_CTRL_AR     1            // ctrl bit, reload at terminal count

// interrupt controller registers
`define PIC_ENABLE      8'h00
`define PIC_PENDING     8'h04
`define PIC_CLEAR       8'h08        // write ones to clear pending
`define PIC_LEVEL       8'h0C

`endif
